// ==== source/refill_pkg.sv ====
package refill_pkg;

    // basic widths on the AXI read side
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  axi_id_t;

    // refill source doubles as the AXI id of its burst
    typedef enum logic [3:0] {
        SRC_ICACHE = 4'd0,
        SRC_DCACHE = 4'd1
    } src_e;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_EXOKAY = 2'b01;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    // cache side request, level plus line address
    typedef struct packed {
        logic  req;
        addr_t addr;
    } rd_req_t;

    // read address payload
    typedef struct packed {
        axi_id_t id;
        addr_t   addr;
    } ar_chan_t;

    // read data payload, one beat
    typedef struct packed {
        axi_id_t id;
        word_t   data;
        resp_t   resp;
        logic    last;
    } r_beat_t;

endpackage

// ==== source/refill_arbiter.sv ====
`timescale 1ns/1ps

module refill_arbiter #(
    parameter int LINE_WORDS = 4 // burst length the slave has to honour
) (
    input  logic                 aclk,
    input  logic                 reset,

    input  refill_pkg::rd_req_t  icache_rd,
    input  refill_pkg::rd_req_t  dcache_rd,
    output logic                 icache_rd_rdy,
    output logic                 dcache_rd_rdy,

    output refill_pkg::ar_chan_t ar,
    output logic                 arvalid,
    input  logic                 arready,

    input  logic                 icache_done,
    input  logic                 dcache_done
);

    // bytes covered by one burst, used to force line alignment
    localparam int LINE_BYTES = LINE_WORDS * 4;

    localparam refill_pkg::addr_t LINE_MASK = ~refill_pkg::addr_t'(LINE_BYTES - 1);

    logic                 icache_busy; // refill outstanding per source
    logic                 dcache_busy;
    logic                 ar_full;
    refill_pkg::ar_chan_t ar_q;

    logic                 dcache_take;
    logic                 icache_take;

    // dcache first, a data miss stalls the whole pipe
    assign dcache_take = dcache_rd.req && !dcache_busy && !ar_full;
    assign icache_take = icache_rd.req && !icache_busy && !ar_full && !dcache_take;

    assign dcache_rd_rdy = dcache_take;
    assign icache_rd_rdy = icache_take;

    assign ar      = ar_q;
    assign arvalid = ar_full;

    // AR holding register, full until the slave takes it
    always_ff @(posedge aclk) begin
        if (reset) begin
            ar_full <= 1'b0;
        end else if (dcache_take || icache_take) begin
            ar_full <= 1'b1;
        end else if (ar_full && arready) begin
            ar_full <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (dcache_take) begin
            ar_q.id   <= refill_pkg::SRC_DCACHE;
            ar_q.addr <= dcache_rd.addr & LINE_MASK;
        end else if (icache_take) begin
            ar_q.id   <= refill_pkg::SRC_ICACHE;
            ar_q.addr <= icache_rd.addr & LINE_MASK;
        end
    end

    // one burst per source in flight
    always_ff @(posedge aclk) begin
        if (reset) begin
            dcache_busy <= 1'b0;
        end else if (dcache_take) begin
            dcache_busy <= 1'b1;
        end else if (dcache_done) begin
            dcache_busy <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            icache_busy <= 1'b0;
        end else if (icache_take) begin
            icache_busy <= 1'b1;
        end else if (icache_done) begin
            icache_busy <= 1'b0;
        end
    end

endmodule

// ==== source/beat_buffer.sv ====
`timescale 1ns/1ps

module beat_buffer #(
    parameter int LINE_WORDS = 4
) (
    input  logic                                aclk,
    input  logic                                reset,

    input  refill_pkg::r_beat_t                 r,
    input  logic                                rvalid,
    output logic                                rready,

    output logic                                line_valid,
    output refill_pkg::src_e                    line_src,
    output refill_pkg::word_t [LINE_WORDS-1:0]  line_data,
    output logic                                line_err
);

    localparam int CNT_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;

    // one assembly slot per id with slot 1 for dcache
    refill_pkg::word_t words [2][LINE_WORDS];
    logic [CNT_W-1:0]  cnt [2];
    logic              err [2];

    logic              beat_fire;
    logic              slot;
    logic              beat_bad;

    assign beat_fire = rvalid && rready;
    assign slot      = (r.id == refill_pkg::SRC_DCACHE);
    assign beat_bad  = (r.resp != refill_pkg::RESP_OKAY);

    // each slot always has room so R is never stalled
    assign rready = !reset;

    always_ff @(posedge aclk) begin
        if (reset) begin
            cnt[0] <= '0;
            cnt[1] <= '0;
            err[0] <= 1'b0;
            err[1] <= 1'b0;
        end else if (beat_fire) begin
            if (r.last) begin // slot free for the next burst
                cnt[slot] <= '0;
                err[slot] <= 1'b0;
            end else begin
                cnt[slot] <= cnt[slot] + CNT_W'(1);
                err[slot] <= err[slot] | beat_bad; // sticky
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (beat_fire && !r.last) begin
            words[slot][cnt[slot]] <= r.data;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            line_valid <= 1'b0;
        end else begin
            line_valid <= beat_fire && r.last;
        end
    end

    // last beat goes straight into the line register
    always_ff @(posedge aclk) begin
        if (beat_fire && r.last) begin
            line_src <= refill_pkg::src_e'(r.id);
            line_err <= err[slot] | beat_bad;
            for (int w = 0; w < LINE_WORDS; w++) begin
                line_data[w] <= (cnt[slot] == CNT_W'(w)) ? r.data : words[slot][w];
            end
        end
    end

endmodule

// ==== source/refill_return.sv ====
`timescale 1ns/1ps

module refill_return #(
    parameter int LINE_WORDS = 4
) (
    input  logic                                aclk,
    input  logic                                reset,

    input  logic                                line_valid,
    input  refill_pkg::src_e                    line_src,
    input  refill_pkg::word_t [LINE_WORDS-1:0]  line_data,
    input  logic                                line_err,

    output logic                                icache_ret_valid,
    output refill_pkg::word_t [LINE_WORDS-1:0]  icache_ret_data,
    output logic                                icache_ret_err,
    output logic                                dcache_ret_valid,
    output refill_pkg::word_t [LINE_WORDS-1:0]  dcache_ret_data,
    output logic                                dcache_ret_err,

    output logic                                icache_done,
    output logic                                dcache_done
);

    logic to_icache;
    logic to_dcache;

    assign to_icache = line_valid && (line_src == refill_pkg::SRC_ICACHE);
    assign to_dcache = line_valid && (line_src == refill_pkg::SRC_DCACHE);

    always_ff @(posedge aclk) begin
        if (reset) begin
            icache_ret_valid <= 1'b0;
            dcache_ret_valid <= 1'b0;
            icache_ret_err   <= 1'b0;
            dcache_ret_err   <= 1'b0;
        end else begin
            icache_ret_valid <= to_icache; // one cycle strobe
            dcache_ret_valid <= to_dcache;
            if (to_icache) icache_ret_err <= line_err;
            if (to_dcache) dcache_ret_err <= line_err;
        end
    end

    // data held until the next return of that source
    always_ff @(posedge aclk) begin
        if (to_icache) begin
            icache_ret_data <= line_data;
        end
        if (to_dcache) begin
            dcache_ret_data <= line_data;
        end
    end

    // release the source in the return cycle
    assign icache_done = icache_ret_valid;
    assign dcache_done = dcache_ret_valid;

endmodule

// ==== source/axi_refill_bridge.sv ====
`timescale 1ns/1ps

module axi_refill_bridge #(
    parameter int LINE_WORDS = 4 // 128 bit lines
) (
    input  logic                                aclk,
    input  logic                                reset,

    input  refill_pkg::rd_req_t                 icache_rd,
    input  refill_pkg::rd_req_t                 dcache_rd,
    output logic                                icache_rd_rdy,
    output logic                                dcache_rd_rdy,

    output refill_pkg::ar_chan_t                ar,
    output logic                                arvalid,
    input  logic                                arready,

    input  refill_pkg::r_beat_t                 r,
    input  logic                                rvalid,
    output logic                                rready,

    output logic                                icache_ret_valid,
    output refill_pkg::word_t [LINE_WORDS-1:0]  icache_ret_data,
    output logic                                icache_ret_err,
    output logic                                dcache_ret_valid,
    output refill_pkg::word_t [LINE_WORDS-1:0]  dcache_ret_data,
    output logic                                dcache_ret_err
);

    logic                               line_valid;
    refill_pkg::src_e                   line_src;
    refill_pkg::word_t [LINE_WORDS-1:0] line_data;
    logic                               line_err;
    logic                               icache_done; // outstanding release
    logic                               dcache_done;

    refill_arbiter #(
        .LINE_WORDS (LINE_WORDS)
    ) u_arbiter (
        .aclk          (aclk         ),
        .reset         (reset        ),
        .icache_rd     (icache_rd    ),
        .dcache_rd     (dcache_rd    ),
        .icache_rd_rdy (icache_rd_rdy),
        .dcache_rd_rdy (dcache_rd_rdy),
        .ar            (ar           ),
        .arvalid       (arvalid      ),
        .arready       (arready      ),
        .icache_done   (icache_done  ),
        .dcache_done   (dcache_done  )
    );

    beat_buffer #(
        .LINE_WORDS (LINE_WORDS)
    ) u_beat_buffer (
        .aclk       (aclk      ),
        .reset      (reset     ),
        .r          (r         ),
        .rvalid     (rvalid    ),
        .rready     (rready    ),
        .line_valid (line_valid),
        .line_src   (line_src  ),
        .line_data  (line_data ),
        .line_err   (line_err  )
    );

    refill_return #(
        .LINE_WORDS (LINE_WORDS)
    ) u_return (
        .aclk             (aclk            ),
        .reset            (reset           ),
        .line_valid       (line_valid      ),
        .line_src         (line_src        ),
        .line_data        (line_data       ),
        .line_err         (line_err        ),
        .icache_ret_valid (icache_ret_valid),
        .icache_ret_data  (icache_ret_data ),
        .icache_ret_err   (icache_ret_err  ),
        .dcache_ret_valid (dcache_ret_valid),
        .dcache_ret_data  (dcache_ret_data ),
        .dcache_ret_err   (dcache_ret_err  ),
        .icache_done      (icache_done     ),
        .dcache_done      (dcache_done     )
    );

endmodule

// ==== test/refill_checker.sv ====
`timescale 1ns/1ps

module refill_checker (
    input logic                 aclk,
    input logic                 reset,
    input refill_pkg::rd_req_t  icache_rd,
    input refill_pkg::rd_req_t  dcache_rd,
    input logic                 icache_rd_rdy,
    input logic                 dcache_rd_rdy,
    input refill_pkg::ar_chan_t ar,
    input logic                 arvalid,
    input logic                 arready,
    input logic                 icache_ret_valid,
    input logic                 dcache_ret_valid
);

    // AR payload held while the slave stalls
    ar_hold: assert property (@(posedge aclk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("ar channel changed before arready");

    irdy_needs_req: assert property (@(posedge aclk) disable iff (reset)
        icache_rd_rdy |-> icache_rd.req)
        else $error("icache_rd_rdy without icache request");

    drdy_needs_req: assert property (@(posedge aclk) disable iff (reset)
        dcache_rd_rdy |-> dcache_rd.req)
        else $error("dcache_rd_rdy without dcache request");

    // one beat per cycle, so one line per cycle
    one_return: assert property (@(posedge aclk) disable iff (reset)
        !(icache_ret_valid && dcache_ret_valid))
        else $error("both return strobes high together");

endmodule

bind axi_refill_bridge refill_checker u_checker (
    .aclk             (aclk            ),
    .reset            (reset           ),
    .icache_rd        (icache_rd       ),
    .dcache_rd        (dcache_rd       ),
    .icache_rd_rdy    (icache_rd_rdy   ),
    .dcache_rd_rdy    (dcache_rd_rdy   ),
    .ar               (ar              ),
    .arvalid          (arvalid         ),
    .arready          (arready         ),
    .icache_ret_valid (icache_ret_valid),
    .dcache_ret_valid (dcache_ret_valid)
);

// ==== test/tb_refill_bridge.sv ====
`timescale 1ns/1ps

module tb_refill_bridge;

    localparam int LINE_WORDS = 4;
    localparam int MAX_LINES  = 64;

    logic aclk;
    logic reset;

    refill_pkg::rd_req_t  icache_rd;
    refill_pkg::rd_req_t  dcache_rd;
    logic                 icache_rd_rdy;
    logic                 dcache_rd_rdy;
    refill_pkg::ar_chan_t ar;
    logic                 arvalid;
    logic                 arready;
    refill_pkg::r_beat_t  r;
    logic                 rvalid;
    logic                 rready;
    logic                 icache_ret_valid;
    logic                 icache_ret_err;
    logic                 dcache_ret_valid;
    logic                 dcache_ret_err;
    refill_pkg::word_t [LINE_WORDS-1:0] icache_ret_data;
    refill_pkg::word_t [LINE_WORDS-1:0] dcache_ret_data;

    // refill table from the stimulus file
    int                 e_start [MAX_LINES];
    int                 e_src   [MAX_LINES];
    refill_pkg::addr_t  e_addr  [MAX_LINES];
    refill_pkg::word_t [LINE_WORDS-1:0] e_line [MAX_LINES];
    int                 e_errbeat [MAX_LINES];
    refill_pkg::resp_t  e_resp  [MAX_LINES];
    int                 n_lines;
    bit                 loaded;

    logic [31:0] lfsr;
    int          cycle;
    int          returned;
    bit          outstanding [2]; // model of the per-source refill flag
    bit          ar_busy;
    int          cur_entry [2];   // entry each cache is requesting
    int          pend [2];        // entry accepted per source
    int          ar_entry;
    bit          open [2];        // burst open in the slave model
    int          beat [2];
    int          last_pick;
    bit          exp_d;
    bit          exp_i;
    int          pick;
    int          r_pick;          // id the slave drives next

    axi_refill_bridge #(
        .LINE_WORDS (LINE_WORDS)
    ) UUT (
        .aclk (aclk), .reset (reset),
        .icache_rd (icache_rd), .dcache_rd (dcache_rd),
        .icache_rd_rdy (icache_rd_rdy), .dcache_rd_rdy (dcache_rd_rdy),
        .ar (ar), .arvalid (arvalid), .arready (arready),
        .r (r), .rvalid (rvalid), .rready (rready),
        .icache_ret_valid (icache_ret_valid), .icache_ret_data (icache_ret_data),
        .icache_ret_err (icache_ret_err),
        .dcache_ret_valid (dcache_ret_valid), .dcache_ret_data (dcache_ret_data),
        .dcache_ret_err (dcache_ret_err)
    );

    always #50 aclk = ~aclk;

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic fail_run();
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_src(input string name, input refill_pkg::src_e got,
                             input refill_pkg::src_e exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_addr(input string name, input refill_pkg::addr_t got,
                              input refill_pkg::addr_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_line(input string name,
                              input refill_pkg::word_t [LINE_WORDS-1:0] got,
                              input refill_pkg::word_t [LINE_WORDS-1:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    cnt;
        int    st, src, eb, rs;
        string line;
        logic [31:0] a, w0, w1, w2, w3;
        fd = $fopen("test/refill_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            fail_run();
        end
        n_lines = 0;
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            cnt = $fgets(line, fd);
            if (cnt > 0 && line.len() > 0 && line[0] != "#") begin
                cnt = $sscanf(line, "%d %d %h %h %h %h %h %d %d",
                              st, src, a, w0, w1, w2, w3, eb, rs);
                if (cnt == 9) begin
                    e_start[n_lines]   = st;
                    e_src[n_lines]     = src;
                    e_addr[n_lines]    = a;
                    e_line[n_lines]    = {w3, w2, w1, w0}; // word 0 low
                    e_errbeat[n_lines] = eb;
                    e_resp[n_lines]    = refill_pkg::resp_t'(rs);
                    n_lines++;
                end
            end
        end
        $fclose(fd);
        if (n_lines == 0) begin
            $display("no refills found in the stimulus file");
            fail_run();
        end
    endtask

    // walk the entries of one cache in file order
    task automatic drive_requests(input int s);
        refill_pkg::rd_req_t req;
        for (int k = 0; k < n_lines; k++) begin
            if (e_src[k] == s) begin
                while (cycle < e_start[k]) @(negedge aclk);
                req.req  = 1'b1;
                req.addr = e_addr[k];
                cur_entry[s] = k;
                if (s == 1) dcache_rd = req;
                else icache_rd = req;
                do @(posedge aclk);
                while (!(s == 1 ? dcache_rd_rdy : icache_rd_rdy));
                @(negedge aclk);
                if (s == 1) dcache_rd = '0;
                else icache_rd = '0;
            end
        end
    endtask

    always @(posedge aclk) begin
        if (reset) cycle <= 0;
        else cycle <= cycle + 1;
    end

    // monitor and slave model sampled at the rising edge
    always @(posedge aclk) begin
        if (!reset && loaded) begin
            exp_d = dcache_rd.req && !outstanding[1] && !ar_busy;
            exp_i = icache_rd.req && !outstanding[0] && !ar_busy && !exp_d;
            check_bit("dcache_rd_rdy", dcache_rd_rdy, exp_d);
            check_bit("icache_rd_rdy", icache_rd_rdy, exp_i);
            check_bit("arvalid", arvalid, ar_busy);
            check_bit("rready", rready, 1'b1);
            if (arvalid && arready) begin
                check_src("ar.id", refill_pkg::src_e'(ar.id),
                          refill_pkg::src_e'(e_src[ar_entry]));
                check_addr("ar.addr", ar.addr, e_addr[ar_entry]);
                open[e_src[ar_entry]] = 1'b1;
                beat[e_src[ar_entry]] = 0;
                ar_busy = 1'b0;
            end
            if (exp_d || exp_i) begin
                pick = exp_d ? 1 : 0;
                outstanding[pick] = 1'b1;
                pend[pick] = cur_entry[pick];
                ar_entry = cur_entry[pick];
                ar_busy = 1'b1;
            end
            if (rvalid && rready) begin
                pick = (r.id == refill_pkg::SRC_DCACHE) ? 1 : 0;
                beat[pick]++;
                last_pick = pick;
                if (r.last) open[pick] = 1'b0;
            end
            if (icache_ret_valid) begin
                if (!outstanding[0]) begin
                    $display("icache return without an outstanding refill");
                    fail_run();
                end
                check_line("icache_ret_data", icache_ret_data, e_line[pend[0]]);
                check_bit("icache_ret_err", icache_ret_err,
                          e_errbeat[pend[0]] >= 0 && e_resp[pend[0]] != 2'b00);
                outstanding[0] = 1'b0;
                returned++;
            end
            if (dcache_ret_valid) begin
                if (!outstanding[1]) begin
                    $display("dcache return without an outstanding refill");
                    fail_run();
                end
                check_line("dcache_ret_data", dcache_ret_data, e_line[pend[1]]);
                check_bit("dcache_ret_err", dcache_ret_err,
                          e_errbeat[pend[1]] >= 0 && e_resp[pend[1]] != 2'b00);
                outstanding[1] = 1'b0;
                returned++;
            end
        end
    end

    // slave drives on the falling edge with random AR wait and R gaps
    always @(negedge aclk) begin
        if (!reset && loaded) begin
            arready = (take_bits(2) == 0);
            if ((open[0] || open[1]) && take_bits(1) == 1) begin
                if (open[0] && open[1]) r_pick = 1 - last_pick; // alternate ids
                else r_pick = open[1] ? 1 : 0;
                r.id   = axi_id_t_of(r_pick);
                r.data = e_line[pend[r_pick]][beat[r_pick]];
                r.resp = (beat[r_pick] == e_errbeat[pend[r_pick]]) ?
                         e_resp[pend[r_pick]] : 2'b00;
                r.last = (beat[r_pick] == LINE_WORDS - 1);
                rvalid = 1'b1;
            end else begin
                rvalid = 1'b0;
            end
        end
    end

    function automatic refill_pkg::axi_id_t axi_id_t_of(input int s);
        return (s == 1) ? refill_pkg::SRC_DCACHE : refill_pkg::SRC_ICACHE;
    endfunction

    initial begin
        wait (loaded);
        #((n_lines * 200 + 1000) * 100);
        $display("timeout, refills did not all return");
        fail_run();
    end

    initial begin
        aclk = 1'b0;
        reset = 1'b1;
        icache_rd = '0;
        dcache_rd = '0;
        arready = 1'b0;
        rvalid = 1'b0;
        r = '0;
        lfsr = 32'h9ea6c964;
        returned = 0;
        ar_busy = 1'b0;
        last_pick = 0;
        r_pick = 0;
        for (int s = 0; s < 2; s++) begin
            outstanding[s] = 1'b0;
            open[s] = 1'b0;
            beat[s] = 0;
            cur_entry[s] = 0;
            pend[s] = 0;
        end
        load_stimulus();
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;
        loaded = 1'b1;
        fork
            drive_requests(0);
            drive_requests(1);
        join_none
        wait (returned == n_lines);
        repeat (5) @(posedge aclk);
        $display("sim passed");
        $finish;
    end

endmodule

// ==== test/refill_stimulus.txt ====
# start_cycle src(0 icache, 1 dcache) line_addr word0 word1 word2 word3 (hex)
# err_beat (-1 for none) resp (0 okay, 2 slverr, 3 decerr)
0 0 00001000 a0000000 a0000001 a0000002 a0000003 -1 0
40 1 00002000 b0000000 b0000001 b0000002 b0000003 -1 0
80 0 00001010 a1000010 a1000011 a1000012 a1000013 -1 0
80 1 00002010 b1000010 b1000011 b1000012 b1000013 -1 0
81 0 00001020 a2000020 a2000021 a2000022 a2000023 -1 0
82 1 00002020 b2000020 b2000021 b2000022 b2000023 -1 0
83 0 00001030 a3000030 a3000031 a3000032 a3000033 -1 0
84 1 00002030 b3000030 b3000031 b3000032 b3000033 -1 0
200 1 00002040 b4000040 b4000041 b4000042 b4000043 2 2
201 1 00002050 b5000050 b5000051 b5000052 b5000053 -1 0
260 0 00001040 a4000040 a4000041 a4000042 a4000043 0 3
261 0 00001050 a5000050 a5000051 a5000052 a5000053 -1 0
320 0 00003000 c0000000 c0000001 c0000002 c0000003 -1 0
320 1 00004000 d0000000 d0000001 d0000002 d0000003 -1 0
321 0 00003010 c1000010 c1000011 c1000012 c1000013 3 2
321 1 00004010 d1000010 d1000011 d1000012 d1000013 1 3
322 0 00003020 c2000020 c2000021 c2000022 c2000023 -1 0
322 1 00004020 d2000020 d2000021 d2000022 d2000023 -1 0
400 0 00005000 e0000000 e0000001 e0000002 e0000003 -1 0
400 1 00006000 f0000000 f0000001 f0000002 f0000003 -1 0
401 0 00005010 e1000010 e1000011 e1000012 e1000013 -1 0
401 1 00006010 f1000010 f1000011 f1000012 f1000013 -1 0
402 0 00005020 e2000020 e2000021 e2000022 e2000023 -1 0
402 1 00006020 f2000020 f2000021 f2000022 f2000023 -1 0
403 0 00005030 e3000030 e3000031 e3000032 e3000033 1 2
403 1 00006030 f3000030 f3000031 f3000032 f3000033 -1 0
404 0 00005040 e4000040 e4000041 e4000042 e4000043 -1 0
404 1 00006040 f4000040 f4000041 f4000042 f4000043 -1 0
500 1 00007000 12345678 9abcdef0 0f1e2d3c 4b5a6978 -1 0
520 0 00008000 deadbeef cafef00d 01234567 89abcdef -1 0

// ==== compile.f ====
source/refill_pkg.sv
source/refill_arbiter.sv
source/beat_buffer.sv
source/refill_return.sv
source/axi_refill_bridge.sv
test/refill_checker.sv
test/tb_refill_bridge.sv

// ==== Makefile ====
# Verilator build for the refill bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_refill_bridge
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= sim passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
